// ==== project.f ====
arm_mode_pkg.sv
regfile_pkg.sv
pipe_stage.sv
bank_decode.sv
banked_regfile.sv
regfile_subsystem.sv
tb_regfile_subsystem.sv

// ==== tb_regfile_subsystem.sv ====
`timescale 1ns/100ps

module tb_regfile_subsystem;

  import arm_mode_pkg::*;
  import regfile_pkg::*;

  localparam int    TOTAL_REQS  = 162; // 9 + 32 + 36 + 15 + 10 + 60
  localparam int    CYCLE_LIMIT = 4 * TOTAL_REQS + 200;
  localparam mode_t MODE_BAD    = 5'b10100; // No such mode

  logic    clk;
  logic    rst_n;
  rf_req_t req;
  logic    req_valid;
  logic    req_ready;
  rf_rsp_t rsp;
  logic    rsp_valid;
  logic    rsp_ready;

  logic [31:0] model [NUM_PHYS] = '{default: '0}; // Reference physical file
  rf_rsp_t     exp_q [$];  // Predicted responses, issue order
  int          cyc_q [$];  // Acceptance cycle of each item
  bit          lat_q [$];  // Latency checked for this item
  int          cycle      = 0;
  int          errors     = 0;
  int          tests_ok   = 0;
  int          tests_bad  = 0;
  bit          bp_en      = 1'b0;
  logic [31:0] bp_state   = 32'h190aef16;
  logic [31:0] stim_state = 32'h190aef16;
  logic [3:0]  next_tag   = '0;
  string       cur_test   = "none";

  regfile_subsystem #(.DATA_W(32)) i_regfile_subsystem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Banking rule, -1 when the register does not exist in this mode
  function automatic int phys_index(input arch_reg_t r, input logic rz, input mode_t m);
    int n;
    n = int'(r);
    if (rz && n == 15) return PHYS_RZ;
    if (m == MODE_FIQ && n >= 8 && n <= 14) return PHYS_FIQ_BASE + n - 8;
    if (n <= 12 || n == 15) return n; // Never banked outside FIQ
    case (m)
      MODE_USR, MODE_SYS: return n;
      MODE_SVC: return PHYS_SVC_BASE + n - 13;
      MODE_ABT: return PHYS_ABT_BASE + n - 13;
      MODE_UND: return PHYS_UND_BASE + n - 13;
      MODE_IRQ: return PHYS_IRQ_BASE + n - 13;
      default:  return -1;
    endcase
  endfunction

  function automatic rf_req_t make_req(input mode_t m, input arch_reg_t a1, input arch_reg_t a2,
                                       input arch_reg_t d, input logic we, input logic [31:0] v,
                                       input logic [2:0] rzf);
    rf_req_t r;
    r       = '0;
    r.mode  = m;
    r.ra1   = a1;
    r.ra2   = a2;
    r.rd    = d;
    r.we    = we;
    r.wdata = v;
    r.rz    = rzf; // {rd, ra2, ra1}
    return r;
  endfunction

  // Hold the request until accepted, then predict its response
  task automatic send(input rf_req_t r_in);
    rf_req_t r;
    rf_rsp_t e;
    int      i1;
    int      i2;
    int      iw;
    r     = r_in;
    r.tag = next_tag;
    next_tag++;
    @(negedge clk);
    req       = r;
    req_valid = 1'b1;
    #1;
    while (!req_ready) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk); // Transfer edge
    i1    = phys_index(r.ra1, r.rz[RZ_RA1], r.mode);
    i2    = phys_index(r.ra2, r.rz[RZ_RA2], r.mode);
    iw    = phys_index(r.rd, r.rz[RZ_RD], r.mode);
    e.rd1 = (i1 < 0) ? '0 : model[i1];
    e.rd2 = (i2 < 0) ? '0 : model[i2];
    e.tag = r.tag;
    if (r.we && iw >= 0) model[iw] = r.wdata; // Reads first, own write unseen
    exp_q.push_back(e);
    cyc_q.push_back(cycle);
    lat_q.push_back(!bp_en);
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0 && waited < 60) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: %0d responses never arrived", cur_test, exp_q.size());
      errors++;
      exp_q.delete();
      cyc_q.delete();
      lat_q.delete();
    end
  endtask

  task automatic finish_test(input int start);
    drain();
    if (errors == start) tests_ok++;
    else tests_bad++;
    $display("%s done with %0d errors", cur_test, errors - start);
  endtask

  // Response monitor, in order against the prediction queue
  always @(posedge clk) begin : monitor
    rf_rsp_t e;
    int      c;
    bit      lat;
    if (rst_n && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("%s: response with tag %0d arrived but none was expected", cur_test, rsp.tag);
        errors++;
      end else begin
        e   = exp_q.pop_front();
        c   = cyc_q.pop_front();
        lat = lat_q.pop_front();
        if (rsp.tag !== e.tag) begin
          $display("Error %s tag expected %0d actual %0d", cur_test, e.tag, rsp.tag);
          errors++;
        end
        if (rsp.rd1 !== e.rd1) begin
          $display("Error %s tag %0d rd1 expected %h actual %h", cur_test, e.tag, e.rd1, rsp.rd1);
          errors++;
        end
        if (rsp.rd2 !== e.rd2) begin
          $display("Error %s tag %0d rd2 expected %h actual %h", cur_test, e.tag, e.rd2, rsp.rd2);
          errors++;
        end
        if (lat && cycle - c != 2) begin
          $display("Error %s tag %0d latency expected 2 actual %0d", cur_test, e.tag, cycle - c);
          errors++;
        end
      end
    end
  end

  // Cycle count, back-pressure and timeout
  always @(negedge clk) begin
    cycle <= cycle + 1;
    if (bp_en) begin
      bp_state = xorshift(bp_state);
      rsp_ready <= (bp_state[1:0] != 2'b00); // Ready about three cycles in four
    end else begin
      rsp_ready <= 1'b1;
    end
    if (cycle >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles with %0d responses pending", cycle, exp_q.size());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic test_reset_state;
    int start;
    start    = errors;
    cur_test = "reset_state";
    repeat (3) begin
      @(negedge clk);
      if (rsp_valid !== 1'b0) begin
        $display("%s: rsp_valid high before any request", cur_test);
        errors++;
      end
    end
    for (int i = 0; i < 16; i += 2) begin
      send(make_req(MODE_USR, arch_reg_t'(i), arch_reg_t'(i + 1), '0, 1'b0, '0, 3'b000));
    end
    send(make_req(MODE_USR, REG_PC, REG_PC, '0, 1'b0, '0, 3'b001)); // Rz starts at zero too
    finish_test(start);
  endtask

  task automatic test_user_system;
    int start;
    start    = errors;
    cur_test = "user_system";
    for (int i = 0; i < 16; i++) begin
      send(make_req(MODE_USR, arch_reg_t'(i), arch_reg_t'(i), arch_reg_t'(i), 1'b1,
                    32'h5a00_0000 + i * 32'h0001_0203, 3'b000));
    end
    for (int i = 0; i < 16; i += 2) begin
      send(make_req(MODE_USR, arch_reg_t'(i), arch_reg_t'(i + 1), '0, 1'b0, '0, 3'b000));
      send(make_req(MODE_SYS, arch_reg_t'(i), arch_reg_t'(i + 1), '0, 1'b0, '0, 3'b000));
    end
    finish_test(start);
  endtask

  task automatic test_exception_banks;
    mode_t banked [5] = '{MODE_SVC, MODE_ABT, MODE_UND, MODE_IRQ, MODE_FIQ};
    int    start;
    start    = errors;
    cur_test = "exception_banks";
    for (int k = 0; k < 4; k++) begin
      send(make_req(banked[k], REG_SP, REG_SP, REG_SP, 1'b1, 32'hb000_0d00 + k, 3'b000));
      send(make_req(banked[k], REG_LR, REG_LR, REG_LR, 1'b1, 32'hb000_0e00 + k, 3'b000));
      for (int j = 0; j < 5; j++) begin
        send(make_req(banked[j], REG_SP, REG_LR, '0, 1'b0, '0, 3'b000)); // Other banks unseen
      end
      send(make_req(MODE_USR, REG_SP, REG_LR, '0, 1'b0, '0, 3'b000));
      send(make_req(banked[k], 4'd0, 4'd12, '0, 1'b0, '0, 3'b000)); // Shared low registers
    end
    finish_test(start);
  endtask

  task automatic test_fiq_bank;
    int start;
    start    = errors;
    cur_test = "fiq_bank";
    for (int i = 8; i < 15; i++) begin
      send(make_req(MODE_FIQ, arch_reg_t'(i), arch_reg_t'(i), arch_reg_t'(i), 1'b1,
                    32'hf100_0000 + i, 3'b000));
    end
    for (int i = 8; i < 16; i += 2) begin
      send(make_req(MODE_FIQ, arch_reg_t'(i), arch_reg_t'(i + 1), '0, 1'b0, '0, 3'b000));
      send(make_req(MODE_USR, arch_reg_t'(i), arch_reg_t'(i + 1), '0, 1'b0, '0, 3'b000));
    end
    finish_test(start);
  endtask

  task automatic test_shadow_invalid;
    int start;
    start    = errors;
    cur_test = "shadow_invalid";
    send(make_req(MODE_USR, REG_PC, REG_PC, REG_PC, 1'b1, 32'h2222_0031, 3'b100)); // Rz write
    send(make_req(MODE_USR, REG_PC, REG_PC, '0, 1'b0, '0, 3'b001)); // Rz vs plain R15
    send(make_req(MODE_SVC, 4'd3, 4'd3, 4'd3, 1'b1, 32'h3333_0003, 3'b111)); // Flags off R15
    send(make_req(MODE_USR, 4'd3, REG_PC, '0, 1'b0, '0, 3'b011));
    send(make_req(MODE_BAD, REG_SP, REG_SP, REG_SP, 1'b1, 32'hdead_0013, 3'b000));
    send(make_req(MODE_BAD, REG_LR, REG_LR, REG_LR, 1'b1, 32'hdead_0014, 3'b000));
    send(make_req(MODE_BAD, REG_SP, REG_LR, '0, 1'b0, '0, 3'b000));
    send(make_req(MODE_BAD, 4'd0, REG_PC, '0, 1'b0, '0, 3'b000)); // Rest still decodes
    send(make_req(MODE_USR, REG_SP, REG_LR, '0, 1'b0, '0, 3'b000));
    send(make_req(MODE_SVC, REG_SP, REG_LR, '0, 1'b0, '0, 3'b000));
    finish_test(start);
  endtask

  task automatic test_random_stream;
    mode_t     modes [8] = '{MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC,
                             MODE_ABT, MODE_UND, MODE_SYS, MODE_BAD};
    rf_req_t   r;
    arch_reg_t last_rd;
    int        start;
    start    = errors;
    cur_test = "random_stream";
    last_rd  = '0;
    bp_en    = 1'b1;
    for (int k = 0; k < 60; k++) begin
      if (k == 30) begin
        drain();
        bp_en = 1'b0; // Second half also checks latency
      end
      stim_state = xorshift(stim_state);
      r = make_req(modes[stim_state[2:0]], stim_state[6] ? last_rd : stim_state[11:8],
                   stim_state[15:12], {1'b1, stim_state[5:3]}, stim_state[16] | stim_state[17],
                   '0, {stim_state[18] & stim_state[19], stim_state[20] & stim_state[21],
                        stim_state[22] & stim_state[23]});
      stim_state = xorshift(stim_state);
      r.wdata    = stim_state;
      last_rd    = r.rd; // Next read often hits this write
      send(r);
    end
    finish_test(start);
  endtask

  initial begin
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_user_system();
    test_exception_banks();
    test_fiq_bank();
    test_shadow_invalid();
    test_random_stream();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== regfile_subsystem.sv ====
`timescale 1ns/100ps

module regfile_subsystem #(
  parameter int DATA_W = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  regfile_pkg::rf_req_t req,
  input  logic                 req_valid,
  output logic                 req_ready,
  output regfile_pkg::rf_rsp_t rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_ready
);

  import regfile_pkg::*;

  rf_dec_t dec_item;             // Straight out of decode
  rf_dec_t dec_q;                // Registered decode
  logic    dec_q_valid;
  logic    dec_q_ready;
  rf_rsp_t rsp_item;             // Read data ahead of the output register
  logic    rsp_item_valid;
  logic    rsp_item_ready;

  // Struct widths come from the package default
  if (DATA_W != regfile_pkg::DATA_W) begin : g_width_check
    $error("DATA_W %0d differs from package width %0d", DATA_W, regfile_pkg::DATA_W);
  end

  bank_decode u_bank_decode (
    .req (req),
    .dec (dec_item)
  );

  pipe_stage #(.payload_t(rf_dec_t)) u_dec_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (dec_item),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .out_data  (dec_q),
    .out_valid (dec_q_valid),
    .out_ready (dec_q_ready)
  );

  banked_regfile #(.DATA_W(DATA_W)) u_banked_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec_q),
    .dec_valid (dec_q_valid),
    .dec_ready (dec_q_ready),
    .rsp       (rsp_item),
    .rsp_valid (rsp_item_valid),
    .rsp_ready (rsp_item_ready)
  );

  pipe_stage #(.payload_t(rf_rsp_t)) u_rsp_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (rsp_item),
    .in_valid  (rsp_item_valid),
    .in_ready  (rsp_item_ready),
    .out_data  (rsp),
    .out_valid (rsp_valid),
    .out_ready (rsp_ready)
  );

endmodule

// ==== banked_regfile.sv ====
`timescale 1ns/100ps

module banked_regfile #(
  parameter int DATA_W = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  regfile_pkg::rf_dec_t dec,
  input  logic                 dec_valid,
  output logic                 dec_ready,
  output regfile_pkg::rf_rsp_t rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_ready
);

  import arm_mode_pkg::*;

  logic [DATA_W-1:0] regs [NUM_PHYS]; // Physical file with all banks
  logic              xfer;            // Item moves on to the response register

  // AND-OR mux over the one-hot select so an empty select reads zero
  function automatic logic [DATA_W-1:0] read_port(phys_sel_t sel);
    logic [DATA_W-1:0] acc;
    acc = '0;
    for (int i = 0; i < NUM_PHYS; i++) begin
      acc |= regs[i] & {DATA_W{sel[i]}};
    end
    return acc;
  endfunction

  // Handshake passes straight through without item storage
  assign dec_ready = rsp_ready;
  assign rsp_valid = dec_valid;
  assign xfer      = dec_valid && rsp_ready;

  // Reads happen before the edge, so an item never sees its own write
  assign rsp.rd1 = read_port(dec.sel1);
  assign rsp.rd2 = read_port(dec.sel2);
  assign rsp.tag = dec.tag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        regs[i] <= '0;
      end
    end else if (xfer && dec.we) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        if (dec.selw[i]) begin
          regs[i] <= dec.wdata; // Empty select drops the write
        end
      end
    end
  end

  // Decode must never hit two registers on one port
  a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> $onehot0(dec.sel1) && $onehot0(dec.sel2) && $onehot0(dec.selw))
    else $error("banked_regfile select not one-hot");

endmodule

// ==== bank_decode.sv ====
`timescale 1ns/100ps

module bank_decode (
  input  regfile_pkg::rf_req_t req,
  output regfile_pkg::rf_dec_t dec
);

  import arm_mode_pkg::*;
  import regfile_pkg::*;

  // Which bank set the current mode uses
  typedef enum logic [2:0] {
    CLS_USR, // User and system
    CLS_FIQ,
    CLS_IRQ,
    CLS_SVC,
    CLS_ABT,
    CLS_UND,
    CLS_BAD  // Undefined mode code
  } mode_cls_t;

  mode_cls_t cls;

  // One classification shared by all three ports
  always_comb begin
    case (req.mode)
      MODE_USR, MODE_SYS: cls = CLS_USR;
      MODE_FIQ:           cls = CLS_FIQ;
      MODE_IRQ:           cls = CLS_IRQ;
      MODE_SVC:           cls = CLS_SVC;
      MODE_ABT:           cls = CLS_ABT;
      MODE_UND:           cls = CLS_UND;
      default:            cls = CLS_BAD;
    endcase
  end

  // Register number, shadow flag and mode class to physical one-hot
  function automatic phys_sel_t map_reg(arch_reg_t r, logic rz, mode_cls_t c);
    phys_sel_t sel;
    phys_idx_t idx;
    logic      hit;
    sel = '0;
    idx = phys_idx_t'(r); // Unbanked by default
    hit = 1'b1;
    if (rz && r == REG_PC) begin
      idx = phys_idx_t'(PHYS_RZ); // Shadow only reachable through R15
    end else if (c == CLS_FIQ && r >= REG_R8 && r <= REG_LR) begin
      idx = phys_idx_t'(PHYS_FIQ_BASE + int'(r - REG_R8));
    end else if (r == REG_SP || r == REG_LR) begin
      // SP and LR banked per exception mode
      case (c)
        CLS_USR: idx = phys_idx_t'(r);
        CLS_SVC: idx = phys_idx_t'(PHYS_SVC_BASE + int'(r - REG_SP));
        CLS_ABT: idx = phys_idx_t'(PHYS_ABT_BASE + int'(r - REG_SP));
        CLS_UND: idx = phys_idx_t'(PHYS_UND_BASE + int'(r - REG_SP));
        CLS_IRQ: idx = phys_idx_t'(PHYS_IRQ_BASE + int'(r - REG_SP));
        default: hit = 1'b0; // Bad mode, no register at all
      endcase
    end
    if (hit) begin
      sel[idx] = 1'b1;
    end
    return sel;
  endfunction

  assign dec.sel1  = map_reg(req.ra1, req.rz[RZ_RA1], cls);
  assign dec.sel2  = map_reg(req.ra2, req.rz[RZ_RA2], cls);
  assign dec.selw  = map_reg(req.rd,  req.rz[RZ_RD],  cls);
  assign dec.we    = req.we;
  assign dec.wdata = req.wdata;
  assign dec.tag   = req.tag; // Carried through for the response

endmodule

// ==== pipe_stage.sv ====
`timescale 1ns/100ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  logic load; // Upstream item accepted this cycle

  // Empty slot, or the held item leaves at this edge
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid; // Refill or drain
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

  // Stalled output keeps its payload
  a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> $stable(out_data))
    else $error("pipe_stage payload changed while stalled");

  // Valid is not withdrawn before the transfer
  a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else $error("pipe_stage dropped valid before transfer");

endmodule

// ==== regfile_pkg.sv ====
package regfile_pkg;

  // Default payload width, the top level cross-checks its own parameter
  localparam int DATA_W = 32;
  localparam int TAG_W  = 4;

  // Bit positions in the rz flag field
  localparam int RZ_RA1 = 0;
  localparam int RZ_RA2 = 1;
  localparam int RZ_RD  = 2;

  // Request as issued by the core
  typedef struct packed {
    arm_mode_pkg::arch_reg_t ra1;   // First source
    arm_mode_pkg::arch_reg_t ra2;   // Second source
    arm_mode_pkg::arch_reg_t rd;    // Destination
    logic                    we;
    logic [DATA_W-1:0]       wdata;
    logic [2:0]              rz;    // Shadow flags, {rd, ra2, ra1}
    arm_mode_pkg::mode_t     mode;  // Current processor mode
    logic [TAG_W-1:0]        tag;   // Returned untouched
  } rf_req_t;

  // After decode, addresses are physical one-hot selects
  typedef struct packed {
    arm_mode_pkg::phys_sel_t sel1;
    arm_mode_pkg::phys_sel_t sel2;
    arm_mode_pkg::phys_sel_t selw;
    logic                    we;
    logic [DATA_W-1:0]       wdata;
    logic [TAG_W-1:0]        tag;
  } rf_dec_t;

  // Read data back to the core
  typedef struct packed {
    logic [DATA_W-1:0] rd1;
    logic [DATA_W-1:0] rd2;
    logic [TAG_W-1:0]  tag;
  } rf_rsp_t;

endpackage

// ==== arm_mode_pkg.sv ====
package arm_mode_pkg;

  // Low five bits of the status register
  typedef logic [4:0] mode_t;

  localparam mode_t MODE_USR = 5'b10000;
  localparam mode_t MODE_FIQ = 5'b10001;
  localparam mode_t MODE_IRQ = 5'b10010;
  localparam mode_t MODE_SVC = 5'b10011;
  localparam mode_t MODE_ABT = 5'b10111;
  localparam mode_t MODE_UND = 5'b11011;
  localparam mode_t MODE_SYS = 5'b11111; // Shares the user file

  // Architectural register number as seen by the instruction
  typedef logic [3:0] arch_reg_t;

  localparam arch_reg_t REG_R8 = 4'd8;  // First register banked in FIQ
  localparam arch_reg_t REG_SP = 4'd13;
  localparam arch_reg_t REG_LR = 4'd14;
  localparam arch_reg_t REG_PC = 4'd15; // Also the Rz alias

  localparam int NUM_PHYS = 32;

  // One-hot physical select, all zero selects nothing
  typedef logic [NUM_PHYS-1:0] phys_sel_t;
  typedef logic [$clog2(NUM_PHYS)-1:0] phys_idx_t;

  // Bank bases in the physical file
  localparam int PHYS_SVC_BASE = 16; // R13_svc, R14_svc
  localparam int PHYS_ABT_BASE = 18;
  localparam int PHYS_UND_BASE = 20;
  localparam int PHYS_IRQ_BASE = 22;
  localparam int PHYS_FIQ_BASE = 24; // R8_fiq up to R14_fiq
  localparam int PHYS_RZ       = 31; // Micro-op shadow register

endpackage
